// ==== list.f ====
+incdir+.
ring_msg_pkg.sv
ring_ctrl_pkg.sv
ring_queue.sv
ring_router.sv
ring_net.sv
ring_net_tb.sv

// ==== ring_ctrl_pkg.sv ====
// control encodings used inside each ring router
// refer to the types as ring_ctrl_pkg::name

`default_nettype none

package ring_ctrl_pkg;

  // ----------------------------------------
  // routing decision
  // ----------------------------------------

  // eject when dest matches this router, otherwise move clockwise
  typedef enum logic {
    ROUTE_EJECT   = 1'b0,
    ROUTE_FORWARD = 1'b1
  } route_e;

  // ----------------------------------------
  // output port arbitration
  // ----------------------------------------

  // requester that won the output port most recently
  // reset value GRANT_INJECT lets ring traffic win first
  typedef enum logic {
    GRANT_RING   = 1'b0,
    GRANT_INJECT = 1'b1
  } grant_e;

endpackage

`default_nettype wire

// ==== ring_msg_pkg.sv ====
// network message format shared by routers, top level and testbench
// refer to the types as ring_msg_pkg::name

`default_nettype none

`include "ring_net_macros.svh"

package ring_msg_pkg;

  // ----------------------------------------
  // terminal numbering
  // ----------------------------------------

  // a terminal number, used for src, dest and router ids
  typedef logic [`RING_SRCDEST_NBITS-1:0] port_idx_t;

  // ----------------------------------------
  // message layout
  // ----------------------------------------

  // dest sits in the top bits, routers only look at it
  // 3 + 3 + 8 + 8 = 22 bits in the default sizing
  typedef struct packed {
    port_idx_t                     dest;
    port_idx_t                     src;
    logic [`RING_OPAQUE_NBITS-1:0] opaque;
    logic [`RING_PAYLOAD_NBITS-1:0] payload;
  } net_msg_t;

endpackage

`default_nettype wire

// ==== ring_net.sv ====
// unidirectional ring of routers, one per terminal
// each port group is a packed array indexed by terminal number

`timescale 1ns/1ps
`default_nettype none

`include "ring_net_macros.svh"

module ring_net (
  input  logic                                         clk,
  input  logic                                         reset,

  input  logic [`RING_NUM_PORTS-1:0]                   in_val,
  output logic [`RING_NUM_PORTS-1:0]                   in_rdy,
  input  ring_msg_pkg::net_msg_t [`RING_NUM_PORTS-1:0] in_msg,

  output logic [`RING_NUM_PORTS-1:0]                   out_val,
  input  logic [`RING_NUM_PORTS-1:0]                   out_rdy,
  output ring_msg_pkg::net_msg_t [`RING_NUM_PORTS-1:0] out_msg
);

  localparam int num_ports = `RING_NUM_PORTS;

  // link i runs from router i to router i+1
  logic [num_ports-1:0]                   link_val;
  logic [num_ports-1:0]                   link_rdy;
  ring_msg_pkg::net_msg_t [num_ports-1:0] link_msg;

  // ----------------------------------------
  // router stages
  // ----------------------------------------

  for (genvar i = 0; i < num_ports; i++)
  begin : g_router
    // upstream link, router 0 closes the ring from the last router
    localparam int prev = (i + num_ports - 1) % num_ports;

    ring_router #(
      .router_id (ring_msg_pkg::port_idx_t'(i))
    ) router_i (
      .clk          (clk),
      .reset        (reset),
      .in_val       (in_val[i]),
      .in_rdy       (in_rdy[i]),
      .in_msg       (in_msg[i]),
      .out_val      (out_val[i]),
      .out_rdy      (out_rdy[i]),
      .out_msg      (out_msg[i]),
      .ring_in_val  (link_val[prev]),
      .ring_in_rdy  (link_rdy[prev]),
      .ring_in_msg  (link_msg[prev]),
      .ring_out_val (link_val[i]),
      .ring_out_rdy (link_rdy[i]),
      .ring_out_msg (link_msg[i])
    );
  end

endmodule

`default_nettype wire

// ==== ring_net_macros.svh ====
// sizing constants for the ring network
// include before any file that sizes ports, fields or queues

`ifndef RING_NET_MACROS_SVH
`define RING_NET_MACROS_SVH

// terminals on the ring, one router each
`define RING_NUM_PORTS 8

// message field widths
`define RING_PAYLOAD_NBITS 8
`define RING_OPAQUE_NBITS 8

// wide enough to name every terminal
`define RING_SRCDEST_NBITS 3

// channel queue entries per router
// bubble flow control needs at least two
`define RING_QUEUE_DEPTH 2

`endif

// ==== ring_net_tb.sv ====
// testbench for the ring network that feeds all eight ports from a message table
// every delivery is checked against per-(src, dest) expected queues

`timescale 1ns/1ps
`default_nettype none

`include "ring_net_macros.svh"

module ring_net_tb;

  localparam int num_ports = `RING_NUM_PORTS;
  // self, one to all, tornado plus neighbour, two hotspot rounds, heavy tornado
  localparam int table_len = 8 + 8 + 16 + 2 * 16 + 5 * 8;
  // every message may need all hops at a few cycles each
  localparam int wd_cycles = table_len * 8 * 4 + 400;

  // one table row
  // the expected output equals the injected message
  typedef struct packed {
    logic [3:0]             test;
    ring_msg_pkg::net_msg_t msg;
  } stim_t;

  logic                                   clk;
  logic                                   reset;
  logic [num_ports-1:0]                   in_val;
  logic [num_ports-1:0]                   in_rdy;
  ring_msg_pkg::net_msg_t [num_ports-1:0] in_msg;
  logic [num_ports-1:0]                   out_val;
  logic [num_ports-1:0]                   out_rdy;
  ring_msg_pkg::net_msg_t [num_ports-1:0] out_msg;

  stim_t                  table_q [$];
  ring_msg_pkg::net_msg_t feed_q [num_ports][$];
  ring_msg_pkg::net_msg_t exp_q [num_ports][num_ports][$];
  int                     pending;
  logic                   stall_en;
  logic [31:0]            rnd_state;
  logic [31:0]            stall_state;

  ring_net dut_i (
    .clk     (clk),
    .reset   (reset),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .in_msg  (in_msg),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .out_msg (out_msg)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_on_error();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_msg(input string name, input ring_msg_pkg::net_msg_t got,
                           input ring_msg_pkg::net_msg_t exp);
    if (got !== exp)
    begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_port(input string name, input ring_msg_pkg::port_idx_t got,
                            input ring_msg_pkg::port_idx_t exp);
    if (got !== exp)
    begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_valid(input string name, input logic [num_ports-1:0] got,
                             input logic [num_ports-1:0] exp);
    if (got !== exp)
    begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  // opaque is the row number and never repeats within a pair
  task automatic add_entry(input int test, input int src, input int dest);
    stim_t row;
    rnd_state = xorshift32(rnd_state);
    row.test        = 4'(test);
    row.msg.dest    = ring_msg_pkg::port_idx_t'(dest % num_ports);
    row.msg.src     = ring_msg_pkg::port_idx_t'(src);
    row.msg.opaque  = `RING_OPAQUE_NBITS'(table_q.size());
    row.msg.payload = rnd_state[`RING_PAYLOAD_NBITS-1:0];
    table_q.push_back(row);
  endtask

  task automatic build_table();
    for (int s = 0; s < num_ports; s++)
      add_entry(2, s, s);
    for (int d = 0; d < num_ports; d++)
      add_entry(3, 0, d);
    // tornado then neighbour patterns wrap past port 7
    for (int s = 0; s < num_ports; s++)
      add_entry(4, s, s + 3);
    for (int s = 0; s < num_ports; s++)
      add_entry(4, s, s + 7);
    // hotspots on the last and first port
    // two messages per pair so their order matters
    for (int k = 0; k < 2; k++)
      for (int s = 0; s < num_ports; s++)
        add_entry(5, s, 7);
    for (int k = 0; k < 2; k++)
      for (int s = 0; s < num_ports; s++)
        add_entry(5, s, 0);
    for (int k = 0; k < 5; k++)
      for (int s = 0; s < num_ports; s++)
        add_entry(6, s, s + 3);
  endtask

  function automatic logic feeders_idle();
    for (int p = 0; p < num_ports; p++)
      if (feed_q[p].size() != 0 || in_val[p])
        return 1'b0;
    return 1'b1;
  endfunction

  // load one test into the feeders and scoreboard, then wait for it to drain
  task automatic run_test(input int t);
    int n;
    int cycles;
    n = 0;
    cycles = 0;
    @(negedge clk);
    stall_en = (t == 6);
    foreach (table_q[i])
    begin
      if (table_q[i].test == 4'(t))
      begin
        feed_q[table_q[i].msg.src].push_back(table_q[i].msg);
        exp_q[table_q[i].msg.src][table_q[i].msg.dest].push_back(table_q[i].msg);
        pending++;
        n++;
      end
    end
    while (!feeders_idle())
      @(negedge clk);
    while (pending != 0 && cycles < n * 8 * 4 + 64)
    begin
      @(negedge clk);
      cycles++;
    end
    if (pending != 0)
    begin
      $display("test %0d ended with %0d expected messages never delivered", t, pending);
      stop_on_error();
    end
  endtask

  // ----------------------------------------
  // feeders and output stalls
  // ----------------------------------------

  always @(posedge clk)
  begin
    stall_state = xorshift32(stall_state);
    for (int p = 0; p < num_ports; p++)
    begin
      if (reset)
      begin
        in_val[p]  <= 1'b0;
        out_rdy[p] <= 1'b1;
      end
      else
      begin
        // transfer on this edge retires the head entry
        if (in_val[p] && in_rdy[p])
          void'(feed_q[p].pop_front());
        if (feed_q[p].size() != 0)
        begin
          in_val[p] <= 1'b1;
          in_msg[p] <= feed_q[p][0];
        end
        else
          in_val[p] <= 1'b0;
        // ready three cycles in four while stalls are on
        out_rdy[p] <= !stall_en || (stall_state[2*p +: 2] != 2'b00);
      end
    end
  end

  // scoreboard pops the queue for this src and this port
  always @(posedge clk)
  begin : monitor
    ring_msg_pkg::net_msg_t got;
    if (!reset)
    begin
      for (int p = 0; p < num_ports; p++)
      begin
        if (out_val[p] && out_rdy[p])
        begin
          got = out_msg[p];
          check_port($sformatf("port of out_msg[%0d]", p),
                     ring_msg_pkg::port_idx_t'(p), got.dest);
          if (exp_q[got.src][p].size() == 0)
          begin
            $display("message %h on port %0d was not expected from src %0d", got, p, got.src);
            stop_on_error();
          end
          else
          begin
            check_msg($sformatf("out_msg[%0d]", p), got, exp_q[got.src][p].pop_front());
            pending--;
          end
        end
      end
    end
  end

  initial
  begin
    repeat (wd_cycles) @(posedge clk);
    $display("timeout after %0d cycles with messages still in flight", wd_cycles);
    stop_on_error();
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial
  begin
    reset       = 1'b1;
    in_val      = '0;
    in_msg      = '0;
    out_rdy     = '1;
    stall_en    = 1'b0;
    pending     = 0;
    rnd_state   = 32'd35144;
    stall_state = 32'd35144;
    build_table();
    if (table_q.size() != table_len)
    begin
      $display("message table has %0d rows instead of %0d", table_q.size(), table_len);
      stop_on_error();
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    // idle network right after reset
    repeat (4)
    begin
      @(negedge clk);
      check_valid("out_val", out_val, '0);
    end
    for (int t = 2; t <= 6; t++)
      run_test(t);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== ring_queue.sv ====
// channel queue toward the clockwise neighbour with valid/ready on both sides
// also reports whether two entries are free for the bubble check

`timescale 1ns/1ps
`default_nettype none

`include "ring_net_macros.svh"

module ring_queue (
  input  logic                   clk,
  input  logic                   reset,

  input  logic                   in_val,
  output logic                   in_rdy,
  input  ring_msg_pkg::net_msg_t in_msg,

  output logic                   out_val,
  input  logic                   out_rdy,
  output ring_msg_pkg::net_msg_t out_msg,

  output logic                   free_two
);

  localparam int depth     = `RING_QUEUE_DEPTH;
  localparam int ptr_nbits = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_nbits = $clog2(depth + 1);

  // message storage
  ring_msg_pkg::net_msg_t entries [depth];

  logic [ptr_nbits-1:0] wr_ptr;
  logic [ptr_nbits-1:0] rd_ptr;
  logic [cnt_nbits-1:0] count;
  logic                 push;
  logic                 pop;

  // wrap pointer at depth for any entry count
  function automatic logic [ptr_nbits-1:0] ptr_next(input logic [ptr_nbits-1:0] ptr);
    if (ptr == ptr_nbits'(depth - 1))
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  // rdy only looks at local occupancy
  // a full queue that pops frees its slot on the next edge
  // keeps rdy paths around the ring free of combinational loops
  assign in_rdy  = (count != cnt_nbits'(depth));
  assign out_val = (count != '0);
  assign out_msg = entries[rd_ptr];

  assign push = in_val && in_rdy;
  assign pop  = out_val && out_rdy;

  // room for an injected message plus the bubble left for the ring
  assign free_two = (count <= cnt_nbits'(depth - 2));

  // ----------------------------------------
  // pointers and occupancy
  // ----------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= ptr_next(wr_ptr);
      if (pop)
        rd_ptr <= ptr_next(rd_ptr);
      // simultaneous push and pop leaves count alone
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // a written message shows at out_msg one cycle later
  always_ff @(posedge clk)
  begin
    if (push)
      entries[wr_ptr] <= in_msg;
  end

endmodule

`default_nettype wire

// ==== ring_router.sv ====
// one ring stage: ejects to the local terminal or forwards clockwise
// injection into the ring obeys the bubble rule, out is shared round robin

`timescale 1ns/1ps
`default_nettype none

`include "ring_net_macros.svh"

module ring_router #(
  parameter ring_msg_pkg::port_idx_t router_id = '0
) (
  input  logic                   clk,
  input  logic                   reset,

  // local injection
  input  logic                   in_val,
  output logic                   in_rdy,
  input  ring_msg_pkg::net_msg_t in_msg,

  // local ejection
  output logic                   out_val,
  input  logic                   out_rdy,
  output ring_msg_pkg::net_msg_t out_msg,

  // from the counter-clockwise neighbour
  input  logic                   ring_in_val,
  output logic                   ring_in_rdy,
  input  ring_msg_pkg::net_msg_t ring_in_msg,

  // to the clockwise neighbour
  output logic                   ring_out_val,
  input  logic                   ring_out_rdy,
  output ring_msg_pkg::net_msg_t ring_out_msg
);

  ring_ctrl_pkg::route_e  ring_route;
  ring_ctrl_pkg::route_e  inj_route;
  ring_ctrl_pkg::grant_e  last_grant;

  logic                   ring_want_out;
  logic                   inj_want_out;
  logic                   ring_out_gnt;
  logic                   inj_out_gnt;

  logic                   ring_fwd;
  logic                   inj_fwd;

  logic                   q_in_val;
  logic                   q_in_rdy;
  ring_msg_pkg::net_msg_t q_in_msg;
  logic                   q_free_two;

  // ----------------------------------------
  // route compute
  // ----------------------------------------

  // only the dest field matters, src is carried along untouched
  assign ring_route = (ring_in_msg.dest == router_id) ? ring_ctrl_pkg::ROUTE_EJECT
                                                      : ring_ctrl_pkg::ROUTE_FORWARD;
  assign inj_route  = (in_msg.dest == router_id) ? ring_ctrl_pkg::ROUTE_EJECT
                                                 : ring_ctrl_pkg::ROUTE_FORWARD;

  assign ring_want_out = ring_in_val && (ring_route == ring_ctrl_pkg::ROUTE_EJECT);
  assign inj_want_out  = in_val && (inj_route == ring_ctrl_pkg::ROUTE_EJECT);

  // ----------------------------------------
  // output arbitration
  // ----------------------------------------

  // on a tie the requester that lost last time wins
  assign ring_out_gnt = ring_want_out &&
                        (!inj_want_out || (last_grant == ring_ctrl_pkg::GRANT_INJECT));
  assign inj_out_gnt  = inj_want_out &&
                        (!ring_want_out || (last_grant == ring_ctrl_pkg::GRANT_RING));

  // ejection path is combinational, same cycle as arrival
  assign out_val = ring_out_gnt || inj_out_gnt;
  assign out_msg = ring_out_gnt ? ring_in_msg : in_msg;

  // round robin state moves only when a message actually leaves on out
  always_ff @(posedge clk)
  begin
    if (reset)
      last_grant <= ring_ctrl_pkg::GRANT_INJECT;
    else if (out_val && out_rdy)
      last_grant <= ring_out_gnt ? ring_ctrl_pkg::GRANT_RING
                                 : ring_ctrl_pkg::GRANT_INJECT;
  end

  // ----------------------------------------
  // channel queue steering
  // ----------------------------------------

  // ring head has priority for the queue
  assign ring_fwd = ring_in_val && (ring_route == ring_ctrl_pkg::ROUTE_FORWARD);

  // bubble rule
  // injection must leave one slot free so ring traffic can always move
  assign inj_fwd = in_val && (inj_route == ring_ctrl_pkg::ROUTE_FORWARD) &&
                   !ring_fwd && q_free_two;

  assign q_in_val = ring_fwd || inj_fwd;
  assign q_in_msg = ring_fwd ? ring_in_msg : in_msg;

  ring_queue queue_i (
    .clk      (clk),
    .reset    (reset),
    .in_val   (q_in_val),
    .in_rdy   (q_in_rdy),
    .in_msg   (q_in_msg),
    .out_val  (ring_out_val),
    .out_rdy  (ring_out_rdy),
    .out_msg  (ring_out_msg),
    .free_two (q_free_two)
  );

  // ----------------------------------------
  // ready back to the senders
  // ----------------------------------------

  // a stalled out_rdy holds the ring head upstream
  assign ring_in_rdy = (ring_route == ring_ctrl_pkg::ROUTE_EJECT) ? (ring_out_gnt && out_rdy)
                                                                  : q_in_rdy;

  // free_two already implies the queue has room
  assign in_rdy = (inj_route == ring_ctrl_pkg::ROUTE_EJECT) ? (inj_out_gnt && out_rdy)
                                                            : (inj_fwd && q_in_rdy);

endmodule

`default_nettype wire
